// ==== mem_cfg_pkg.sv ====
`default_nettype none

package mem_cfg_pkg;

  // data word
  localparam int WIDTH = 16;

  // flat address space
  localparam int NUMADDR = 96;
  localparam int BITADDR = 7;

  // banking, three banks so mapping needs a real divide
  localparam int NUMVBNK = 3;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 32;
  localparam int BITVROW = 5;

  // physical address is bank over row
  localparam int BITPADR = BITVBNK + BITVROW;

  // two read ports, one write port
  localparam int NUMRDPT = 2;

  // bank read delay in cycles
  localparam int SRAM_DELAY = 2;

  // reset release stages, ready included
  localparam int RST_SYNC_LEN = 3;

endpackage

`default_nettype wire

// ==== mem_types_pkg.sv ====
`default_nettype none

package mem_types_pkg;

  // flat address as seen on the ports
  typedef logic [mem_cfg_pkg::BITADDR-1:0] vaddr_t;

  // bank number and row inside bank
  typedef logic [mem_cfg_pkg::BITVBNK-1:0] vbank_t;
  typedef logic [mem_cfg_pkg::BITVROW-1:0] vrow_t;

  // data word
  typedef logic [mem_cfg_pkg::WIDTH-1:0] data_t;

  // physical address split into its two fields
  // bank sits in the upper bits
  typedef struct packed {
    vbank_t bank;
    vrow_t  row;
  } padr_fields_t;

  // same word seen as fields or as one flat value
  typedef union packed {
    padr_fields_t                    f;
    logic [mem_cfg_pkg::BITPADR-1:0] flat;
  } padr_u;

endpackage

`default_nettype wire

// ==== np2_addr_map.sv ====
`default_nettype none

module np2_addr_map (
  input  mem_types_pkg::vaddr_t vaddr,
  output mem_types_pkg::vbank_t vbadr,
  output mem_types_pkg::vrow_t  vradr
);

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  // bank count as an address-wide constant
  localparam vaddr_t DIVISOR = vaddr_t'(NUMVBNK);

  // quotient of the flat address
  vrow_t  row_q;
  // row scaled back up by three
  vaddr_t row_x3;
  // remainder, always below three
  vaddr_t rem;

  // row is address div 3
  // inputs stay below 96 so the quotient fits five bits
  assign row_q = vrow_t'(vaddr / DIVISOR);

  // 3 * row as shift plus add
  assign row_x3 = vaddr_t'({row_q, 1'b0}) + vaddr_t'(row_q);

  // bank is what is left over
  assign rem = vaddr - row_x3;

  assign vradr = row_q;
  assign vbadr = vbank_t'(rem);

endmodule

`default_nettype wire

// ==== port_ctrl.sv ====
`default_nettype none

module port_ctrl (
  input  logic                  clk,
  input  logic                  arst_n,
  // write request, already mapped
  input  logic                  vwrite,
  input  mem_types_pkg::vbank_t vwbadr,
  input  mem_types_pkg::vrow_t  vwradr,
  input  mem_types_pkg::data_t  vdin,
  // read requests, already mapped
  input  logic                  vread_0,
  input  logic                  vread_1,
  input  mem_types_pkg::vbank_t vrbadr_0,
  input  mem_types_pkg::vbank_t vrbadr_1,
  input  mem_types_pkg::vrow_t  vrradr_0,
  input  mem_types_pkg::vrow_t  vrradr_1,
  output logic                  ready,
  // gated write to banks
  output logic                  pwrite,
  output mem_types_pkg::vbank_t pwbadr,
  output mem_types_pkg::vrow_t  pwradr,
  output mem_types_pkg::data_t  pdin,
  // gated reads to banks
  output logic                  pread_0,
  output logic                  pread_1,
  output mem_types_pkg::vbank_t prbadr_0,
  output mem_types_pkg::vbank_t prbadr_1,
  output mem_types_pkg::vrow_t  prradr_0,
  output mem_types_pkg::vrow_t  prradr_1,
  // delayed read info, lined up with bank data
  output logic                  rd_vld_0,
  output logic                  rd_vld_1,
  output mem_types_pkg::vbank_t rd_bank_0,
  output mem_types_pkg::vbank_t rd_bank_1,
  output mem_types_pkg::vrow_t  rd_row_0,
  output mem_types_pkg::vrow_t  rd_row_1
);

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  // release chain, ready flop is the last stage
  logic [RST_SYNC_LEN-2:0] rst_sync;
  // port 1 lost the bank to port 0
  logic                    rd_conflict;

  // read pipes, index [stage][port]
  logic [NUMRDPT-1:0] vld_pipe  [SRAM_DELAY];
  vbank_t             bank_pipe [SRAM_DELAY][NUMRDPT];
  vrow_t              row_pipe  [SRAM_DELAY][NUMRDPT];

  // assert at once, release after RST_SYNC_LEN edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= '0;
      ready    <= 1'b0;
    end else begin
      rst_sync <= {rst_sync[RST_SYNC_LEN-3:0], 1'b1};
      ready    <= rst_sync[RST_SYNC_LEN-2];
    end
  end

  // write passes straight through, strobe gated
  assign pwrite = vwrite & ready;
  assign pwbadr = vwbadr;
  assign pwradr = vwradr;
  assign pdin   = vdin;

  // one read per bank per cycle, port 0 has priority
  assign pread_0     = vread_0 & ready;
  assign rd_conflict = pread_0 && (vrbadr_0 == vrbadr_1);
  assign pread_1     = vread_1 & ready & ~rd_conflict;

  assign prbadr_0 = vrbadr_0;
  assign prbadr_1 = vrbadr_1;
  assign prradr_0 = vrradr_0;
  assign prradr_1 = vrradr_1;

  // accepted strobes follow the bank read delay
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int s = 0; s < SRAM_DELAY; s++) begin
        vld_pipe[s] <= '0;
      end
    end else begin
      vld_pipe[0] <= {pread_1, pread_0};
      for (int s = 1; s < SRAM_DELAY; s++) begin
        vld_pipe[s] <= vld_pipe[s-1];
      end
    end
  end

  // bank and row ride along, qualified by vld
  always_ff @(posedge clk) begin
    bank_pipe[0][0] <= vrbadr_0;
    bank_pipe[0][1] <= vrbadr_1;
    row_pipe[0][0]  <= vrradr_0;
    row_pipe[0][1]  <= vrradr_1;
    for (int s = 1; s < SRAM_DELAY; s++) begin
      bank_pipe[s] <= bank_pipe[s-1];
      row_pipe[s]  <= row_pipe[s-1];
    end
  end

  assign rd_vld_0  = vld_pipe[SRAM_DELAY-1][0];
  assign rd_vld_1  = vld_pipe[SRAM_DELAY-1][1];
  assign rd_bank_0 = bank_pipe[SRAM_DELAY-1][0];
  assign rd_bank_1 = bank_pipe[SRAM_DELAY-1][1];
  assign rd_row_0  = row_pipe[SRAM_DELAY-1][0];
  assign rd_row_1  = row_pipe[SRAM_DELAY-1][1];

endmodule

`default_nettype wire

// ==== bank_array.sv ====
`default_nettype none

module bank_array (
  input  logic                  clk,
  // single write port
  input  logic                  pwrite,
  input  mem_types_pkg::vbank_t pwbadr,
  input  mem_types_pkg::vrow_t  pwradr,
  input  mem_types_pkg::data_t  pdin,
  // two read ports, never on the same bank
  input  logic                  pread_0,
  input  logic                  pread_1,
  input  mem_types_pkg::vbank_t prbadr_0,
  input  mem_types_pkg::vbank_t prbadr_1,
  input  mem_types_pkg::vrow_t  prradr_0,
  input  mem_types_pkg::vrow_t  prradr_1,
  // per-bank read words after the delay
  output mem_types_pkg::data_t  bank_dout_0,
  output mem_types_pkg::data_t  bank_dout_1,
  output mem_types_pkg::data_t  bank_dout_2
);

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  data_t bank_dout [NUMVBNK];

  for (genvar b = 0; b < NUMVBNK; b++) begin : g_bank
    // one 1R1W bank
    data_t mem     [NUMVROW];
    // read data delay line
    data_t rd_pipe [SRAM_DELAY];
    logic  hit_0;
    logic  hit_1;
    logic  wr_en;
    logic  rd_en;
    vrow_t rd_row;

    // which read port owns this bank this cycle
    assign hit_0  = pread_0 && (prbadr_0 == vbank_t'(b));
    assign hit_1  = pread_1 && (prbadr_1 == vbank_t'(b));
    assign rd_en  = hit_0 | hit_1;
    assign rd_row = hit_0 ? prradr_0 : prradr_1;
    assign wr_en  = pwrite && (pwbadr == vbank_t'(b));

    // write lands at the edge
    // read at the same edge still sees the old word
    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[pwradr] <= pdin;
      end
      if (rd_en) begin
        rd_pipe[0] <= mem[rd_row];
      end
      for (int s = 1; s < SRAM_DELAY; s++) begin
        rd_pipe[s] <= rd_pipe[s-1];
      end
    end

    assign bank_dout[b] = rd_pipe[SRAM_DELAY-1];
  end

  assign bank_dout_0 = bank_dout[0];
  assign bank_dout_1 = bank_dout[1];
  assign bank_dout_2 = bank_dout[2];

endmodule

`default_nettype wire

// ==== rd_out_mux.sv ====
`default_nettype none

module rd_out_mux (
  // delayed read info from the control pipes
  input  logic                            rd_vld_0,
  input  logic                            rd_vld_1,
  input  mem_types_pkg::vbank_t           rd_bank_0,
  input  mem_types_pkg::vbank_t           rd_bank_1,
  input  mem_types_pkg::vrow_t            rd_row_0,
  input  mem_types_pkg::vrow_t            rd_row_1,
  // bank read words
  input  mem_types_pkg::data_t            bank_dout_0,
  input  mem_types_pkg::data_t            bank_dout_1,
  input  mem_types_pkg::data_t            bank_dout_2,
  output logic                            vread_vld_0,
  output logic                            vread_vld_1,
  output mem_types_pkg::data_t            vdout_0,
  output mem_types_pkg::data_t            vdout_1,
  output logic [mem_cfg_pkg::BITPADR-1:0] vread_padr_0,
  output logic [mem_cfg_pkg::BITPADR-1:0] vread_padr_1
);

  import mem_types_pkg::*;

  padr_u padr_0;
  padr_u padr_1;

  // bank select, only banks 0 to 2 exist
  function automatic data_t pick_bank(input vbank_t b, input data_t d0,
                                      input data_t d1, input data_t d2);
    case (b)
      2'd0:    pick_bank = d0;
      2'd1:    pick_bank = d1;
      default: pick_bank = d2;
    endcase
  endfunction

  assign vdout_0 = pick_bank(rd_bank_0, bank_dout_0, bank_dout_1, bank_dout_2);
  assign vdout_1 = pick_bank(rd_bank_1, bank_dout_0, bank_dout_1, bank_dout_2);

  // physical address built by field, sent out flat
  always_comb begin
    padr_0.f.bank = rd_bank_0;
    padr_0.f.row  = rd_row_0;
    padr_1.f.bank = rd_bank_1;
    padr_1.f.row  = rd_row_1;
  end

  assign vread_padr_0 = padr_0.flat;
  assign vread_padr_1 = padr_1.flat;

  // valid already aligned with the data
  assign vread_vld_0 = rd_vld_0;
  assign vread_vld_1 = rd_vld_1;

endmodule

`default_nettype wire

// ==== mrpnwp_top.sv ====
`default_nettype none

module mrpnwp_top (
  input  logic                            clk,
  input  logic                            arst_n,
  // write port
  input  logic                            vwrite,
  input  mem_types_pkg::vaddr_t           vwraddr,
  input  mem_types_pkg::data_t            vdin,
  // read port 0
  input  logic                            vread_0,
  input  mem_types_pkg::vaddr_t           vrdaddr_0,
  output logic                            vread_vld_0,
  output mem_types_pkg::data_t            vdout_0,
  output logic [mem_cfg_pkg::BITPADR-1:0] vread_padr_0,
  // read port 1
  input  logic                            vread_1,
  input  mem_types_pkg::vaddr_t           vrdaddr_1,
  output logic                            vread_vld_1,
  output mem_types_pkg::data_t            vdout_1,
  output logic [mem_cfg_pkg::BITPADR-1:0] vread_padr_1,
  output logic                            ready
);

  import mem_types_pkg::*;

  // mapped request addresses
  vbank_t vwbadr, vrbadr_0, vrbadr_1;
  vrow_t  vwradr, vrradr_0, vrradr_1;

  // gated bank requests
  logic   pwrite, pread_0, pread_1;
  vbank_t pwbadr, prbadr_0, prbadr_1;
  vrow_t  pwradr, prradr_0, prradr_1;
  data_t  pdin;

  // delayed read info and bank data
  logic   rd_vld_0, rd_vld_1;
  vbank_t rd_bank_0, rd_bank_1;
  vrow_t  rd_row_0, rd_row_1;
  data_t  bank_dout_0, bank_dout_1, bank_dout_2;

  np2_addr_map wr_map_inst (.vaddr(vwraddr), .vbadr(vwbadr), .vradr(vwradr));
  np2_addr_map rd0_map_inst (.vaddr(vrdaddr_0), .vbadr(vrbadr_0), .vradr(vrradr_0));
  np2_addr_map rd1_map_inst (.vaddr(vrdaddr_1), .vbadr(vrbadr_1), .vradr(vrradr_1));

  port_ctrl port_ctrl_inst (
    .clk(clk), .arst_n(arst_n),
    .vwrite(vwrite), .vwbadr(vwbadr), .vwradr(vwradr), .vdin(vdin),
    .vread_0(vread_0), .vread_1(vread_1),
    .vrbadr_0(vrbadr_0), .vrbadr_1(vrbadr_1),
    .vrradr_0(vrradr_0), .vrradr_1(vrradr_1),
    .ready(ready),
    .pwrite(pwrite), .pwbadr(pwbadr), .pwradr(pwradr), .pdin(pdin),
    .pread_0(pread_0), .pread_1(pread_1),
    .prbadr_0(prbadr_0), .prbadr_1(prbadr_1),
    .prradr_0(prradr_0), .prradr_1(prradr_1),
    .rd_vld_0(rd_vld_0), .rd_vld_1(rd_vld_1),
    .rd_bank_0(rd_bank_0), .rd_bank_1(rd_bank_1),
    .rd_row_0(rd_row_0), .rd_row_1(rd_row_1)
  );

  bank_array bank_array_inst (
    .clk(clk),
    .pwrite(pwrite), .pwbadr(pwbadr), .pwradr(pwradr), .pdin(pdin),
    .pread_0(pread_0), .pread_1(pread_1),
    .prbadr_0(prbadr_0), .prbadr_1(prbadr_1),
    .prradr_0(prradr_0), .prradr_1(prradr_1),
    .bank_dout_0(bank_dout_0), .bank_dout_1(bank_dout_1), .bank_dout_2(bank_dout_2)
  );

  rd_out_mux rd_out_mux_inst (
    .rd_vld_0(rd_vld_0), .rd_vld_1(rd_vld_1),
    .rd_bank_0(rd_bank_0), .rd_bank_1(rd_bank_1),
    .rd_row_0(rd_row_0), .rd_row_1(rd_row_1),
    .bank_dout_0(bank_dout_0), .bank_dout_1(bank_dout_1), .bank_dout_2(bank_dout_2),
    .vread_vld_0(vread_vld_0), .vread_vld_1(vread_vld_1),
    .vdout_0(vdout_0), .vdout_1(vdout_1),
    .vread_padr_0(vread_padr_0), .vread_padr_1(vread_padr_1)
  );

endmodule

`default_nettype wire

// ==== mrpnwp_props.sv ====
`default_nettype none

module mrpnwp_props (
  input logic                  clk,
  input logic                  arst_n,
  input logic                  ready,
  input logic                  pwrite,
  input logic                  pread_0,
  input logic                  pread_1,
  input mem_types_pkg::vbank_t prbadr_0,
  input mem_types_pkg::vbank_t prbadr_1
);

  // ready drops with reset
  ready_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ready)
    else $error("ready high while reset is asserted");

  // each bank has a single read port
  one_read_per_bank: assert property (@(posedge clk) disable iff (!arst_n)
    !(pread_0 && pread_1 && (prbadr_0 == prbadr_1)))
    else $error("both read ports granted the same bank");

  // no bank access until ready
  no_access_before_ready: assert property (@(posedge clk)
    !ready |-> !(pwrite || pread_0 || pread_1))
    else $error("bank access while ready is low");

endmodule

`default_nettype wire

// ==== tb_mrpnwp.sv ====
`default_nettype none

module tb_mrpnwp;

  import mem_cfg_pkg::*;
  import mem_types_pkg::*;

  localparam int    CLK_PERIOD = 8;
  localparam int    MAX_OPS    = 64;
  localparam string DATA_FILE  = "mrpnwp_input.txt";

  int seed = 33;

  logic               clk;
  logic               arst_n;
  logic               vwrite;
  vaddr_t             vwraddr;
  data_t              vdin;
  logic               vread_0, vread_1, vread_vld_0, vread_vld_1, ready;
  vaddr_t             vrdaddr_0, vrdaddr_1;
  data_t              vdout_0, vdout_1;
  logic [BITPADR-1:0] vread_padr_0, vread_padr_1;

  // one operation per file line, two idle drain ops appended
  string  op_name [MAX_OPS];
  logic   op_wr   [MAX_OPS];
  vaddr_t op_waddr[MAX_OPS];
  data_t  op_wdata[MAX_OPS];
  logic   op_rd   [MAX_OPS][2];
  vaddr_t op_raddr[MAX_OPS][2];
  logic   exp_vld [MAX_OPS][2];
  data_t  exp_data[MAX_OPS][2];
  int     n_ops  = 0;
  bit     loaded = 1'b0;
  // ops in flight, oldest first
  int     issued[$];

  mrpnwp_top mrpnwp_top_inst (
    .clk(clk), .arst_n(arst_n),
    .vwrite(vwrite), .vwraddr(vwraddr), .vdin(vdin),
    .vread_0(vread_0), .vrdaddr_0(vrdaddr_0), .vread_vld_0(vread_vld_0),
    .vdout_0(vdout_0), .vread_padr_0(vread_padr_0),
    .vread_1(vread_1), .vrdaddr_1(vrdaddr_1), .vread_vld_1(vread_vld_1),
    .vdout_1(vdout_1), .vread_padr_1(vread_padr_1),
    .ready(ready)
  );

  bind port_ctrl mrpnwp_props props_inst (
    .clk(clk), .arst_n(arst_n), .ready(ready), .pwrite(pwrite),
    .pread_0(pread_0), .pread_1(pread_1), .prbadr_0(prbadr_0), .prbadr_1(prbadr_1)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s data expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_vld(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("MISMATCH %s valid expected %0b actual %0b", name, exp, act));
    end
  endtask

  task automatic check_padr(input string name, input padr_u exp, input padr_u act);
    if (act.flat !== exp.flat) begin
      abort_run($sformatf("MISMATCH %s padr expected bank %0d row %0d actual bank %0d row %0d",
                          name, exp.f.bank, exp.f.row, act.f.bank, act.f.row));
    end
  endtask

  // bank is addr mod 3, row is addr div 3
  function automatic padr_u expect_padr(input vaddr_t addr);
    padr_u p;
    p.f.bank = vbank_t'(addr % 3);
    p.f.row  = vrow_t'(addr / 3);
    return p;
  endfunction

  task automatic load_ops();
    int     fd;
    int     cnt;
    string  line, name, wtok;
    logic   wr, rd0, rd1, ev0, ev1;
    vaddr_t wa, ra0, ra1;
    data_t  wd, ed0, ed1;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open stimulus file %s", DATA_FILE));
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // skip blanks and column notes
      if (line.len() < 2 || line.getc(0) == "#") continue;
      cnt = $sscanf(line, "%s %h %h %s %h %h %h %h %h %h %h %h",
                    name, wr, wa, wtok, rd0, ra0, rd1, ra1, ev0, ed0, ev1, ed1);
      if (cnt != 12 || n_ops >= MAX_OPS - 2) begin
        abort_run($sformatf("stimulus line could not be used: %s", line));
      end
      // filler writes, never read back
      if (wtok == "rand") wd = data_t'($random(seed));
      else void'($sscanf(wtok, "%h", wd));
      op_name[n_ops]     = name;
      op_wr[n_ops]       = wr;
      op_waddr[n_ops]    = wa;
      op_wdata[n_ops]    = wd;
      op_rd[n_ops]       = '{rd0, rd1};
      op_raddr[n_ops]    = '{ra0, ra1};
      exp_vld[n_ops]     = '{ev0, ev1};
      exp_data[n_ops]    = '{ed0, ed1};
      n_ops++;
    end
    $fclose(fd);
    // idle tail so the last reads come out
    for (int k = 0; k < 2; k++) begin
      op_name[n_ops]  = "drain";
      op_wr[n_ops]    = 1'b0;
      op_waddr[n_ops] = '0;
      op_wdata[n_ops] = '0;
      op_rd[n_ops]    = '{1'b0, 1'b0};
      op_raddr[n_ops] = '{vaddr_t'(0), vaddr_t'(0)};
      exp_vld[n_ops]  = '{1'b0, 1'b0};
      n_ops++;
    end
    loaded = 1'b1;
  endtask

  task automatic drive_op(input int i);
    vwrite    = op_wr[i];
    vwraddr   = op_waddr[i];
    vdin      = op_wdata[i];
    vread_0   = op_rd[i][0];
    vrdaddr_0 = op_raddr[i][0];
    vread_1   = op_rd[i][1];
    vrdaddr_1 = op_raddr[i][1];
  endtask

  task automatic check_port(input int i, input int p, input logic vld, input data_t dout,
                            input logic [BITPADR-1:0] padr);
    padr_u act;
    string tag;
    act.flat = padr;
    tag = $sformatf("%s port %0d", op_name[i], p);
    check_vld(tag, exp_vld[i][p], vld);
    // data only matters with valid
    if (exp_vld[i][p]) begin
      check_data(tag, exp_data[i][p], dout);
      check_padr(tag, expect_padr(op_raddr[i][p]), act);
    end
  endtask

  initial begin
    int wait_cycles;
    arst_n    = 1'b0;
    vwrite    = 1'b0;
    vwraddr   = '0;
    vdin      = '0;
    // reads held high through reset, must be ignored
    vread_0   = 1'b1;
    vread_1   = 1'b1;
    vrdaddr_0 = 7'h04;
    vrdaddr_1 = 7'h08;
    load_ops();
    repeat (8) begin
      @(negedge clk);
      check_vld("reset ready", 1'b0, ready);
      check_vld("reset port 0", 1'b0, vread_vld_0);
      check_vld("reset port 1", 1'b0, vread_vld_1);
    end
    arst_n = 1'b1;
    wait_cycles = 0;
    while (ready !== 1'b1) begin
      @(negedge clk);
      wait_cycles++;
      check_vld("release port 0", 1'b0, vread_vld_0);
      check_vld("release port 1", 1'b0, vread_vld_1);
    end
    if (wait_cycles != RST_SYNC_LEN) begin
      abort_run($sformatf("MISMATCH ready_delay expected %0d actual %0d",
                          RST_SYNC_LEN, wait_cycles));
    end
    // results come back two cycles after issue
    for (int i = 0; i < n_ops; i++) begin
      if (issued.size() == 2) begin
        check_port(issued[0], 0, vread_vld_0, vdout_0, vread_padr_0);
        check_port(issued[0], 1, vread_vld_1, vdout_1, vread_padr_1);
        void'(issued.pop_front());
      end
      drive_op(i);
      issued.push_back(i);
      @(negedge clk);
    end
    $display("Test completed successfully");
    $finish;
  end

  // limit scales with the number of operations
  initial begin
    wait (loaded);
    #((n_ops + 20) * CLK_PERIOD * 2);
    $display("run timed out before all operations finished");
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== mrpnwp_input.txt ====
# name wr waddr wdata(hex or rand) rd0 raddr0 rd1 raddr1 vld0 data0 vld1 data1
# all numbers hex, addresses are flat 0..5f
wr_b0          1 00 1a00 0 00 0 00 0 0000 0 0000
wr_b1          1 01 1a01 0 00 0 00 0 0000 0 0000
wr_b2          1 02 1a02 0 00 0 00 0 0000 0 0000
wr_top         1 5f beef 0 00 0 00 0 0000 0 0000
wr_mid         1 28 c028 0 00 0 00 0 0000 0 0000
rd_b0_b1       0 00 0000 1 00 1 01 1 1a00 1 1a01
conflict_b2    0 00 0000 1 02 1 5f 1 1a02 0 0000
rd_b1_b0       0 00 0000 1 28 1 00 1 c028 1 1a00
rd_p1_top      0 00 0000 0 00 1 5f 0 0000 1 beef
conflict_b0    0 00 0000 1 00 1 00 1 1a00 0 0000
conflict_b1    0 00 0000 1 01 1 28 1 1a01 0 0000
fill_rand0     1 3c rand 0 00 0 00 0 0000 0 0000
same_cycle     1 01 2b01 1 01 0 00 1 1a01 0 0000
next_cycle     0 00 0000 1 01 1 02 1 2b01 1 1a02
b2b_0          0 00 0000 1 00 1 28 1 1a00 1 c028
b2b_1          0 00 0000 1 02 1 01 1 1a02 1 2b01
b2b_2          0 00 0000 1 5f 1 00 1 beef 1 1a00
fill_rand1     1 4b rand 1 28 0 00 1 c028 0 0000
idle           0 00 0000 0 00 0 00 0 0000 0 0000

// ==== files.f ====
mem_cfg_pkg.sv
mem_types_pkg.sv
np2_addr_map.sv
port_ctrl.sv
bank_array.sv
rd_out_mux.sv
mrpnwp_top.sv
mrpnwp_props.sv
tb_mrpnwp.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_mrpnwp
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
